//--- Bender.yml
package:
  name: output_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/out_stage_pkg.sv
      - common/ram_port_if.sv
      - output_buffer/dual_write_ram.sv
      - output_buffer/bank_switch.sv
      - output_buffer/drain_reader.sv
      - hdl/word_fill.sv
      - hdl/output_stage_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_output_stage.sv

//--- common/out_stage_defs.svh
// Bank geometry of the output stage. The depth is always a power of two set by the address width.
`ifndef OUT_STAGE_DEFS_SVH
`define OUT_STAGE_DEFS_SVH

// Address bits of one bank.
`define OUT_ADDR_W 10

// 16-bit words per bank.
`define OUT_DEPTH (1 << `OUT_ADDR_W)

`endif

//--- common/out_stage_pkg.sv
// Shared types of the output stage. Coded words are fixed at 16 bits and beats at 32 bits.
package out_stage_pkg;

`include "out_stage_defs.svh"

    typedef logic [15:0] word_t;               // One coded word.
    typedef logic [31:0] beat_t;               // One output beat, two words.
    typedef logic [`OUT_ADDR_W-1:0] addr_t;    // Bank address.
    typedef logic [`OUT_ADDR_W:0] count_t;     // Word count, 0 up to a full bank.

    // Packs an address pair into one beat with the bytes of each word swapped.
    function automatic beat_t pack_beat(input word_t even_word, input word_t odd_word);
        return {odd_word[7:0], odd_word[15:8], even_word[7:0], even_word[15:8]};
    endfunction

endpackage

//--- common/ram_port_if.sv
// One write port and one registered read port of a bank. Read data lags the address by one cycle.
`timescale 1ns/1ps

interface ram_port_if import out_stage_pkg::*; ();

    logic  we;
    addr_t waddr;
    word_t wdata;
    addr_t raddr;
    word_t rdata;

    modport user (
        output we,
        output waddr,
        output wdata,
        output raddr,
        input  rdata
    );

    modport ram (
        input  we,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface

//--- hdl/output_stage_top.sv
// Output stage of the encoder. The consumer cannot stall the 32-bit stream except through enable.
`timescale 1ns/1ps

module output_stage_top import out_stage_pkg::*; (
    input  logic  iClock,
    input  logic  reset,
    input  logic  enable,
    input  logic  clear,
    input  logic  word_valid,
    input  word_t word_data,
    input  logic  frame_done,
    output beat_t data,
    output logic  valid
);

    count_t fill_count;
    count_t drain_count;
    logic   drain_start;
    logic   drain_busy;

    ram_port_if fill_a ();
    ram_port_if fill_b ();
    ram_port_if drain_a ();
    ram_port_if drain_b ();
    ram_port_if bank0_a ();
    ram_port_if bank0_b ();
    ram_port_if bank1_a ();
    ram_port_if bank1_b ();

    word_fill word_fill_i (
        .iClock     (iClock),
        .reset      (reset),
        .enable     (enable),
        .clear      (clear),
        .word_valid (word_valid),
        .word_data  (word_data),
        .frame_done (frame_done),
        .fill_count (fill_count),
        .fill_a     (fill_a.user),
        .fill_b     (fill_b.user)
    );

    bank_switch bank_switch_i (
        .iClock      (iClock),
        .reset       (reset),
        .enable      (enable),
        .clear       (clear),
        .frame_done  (frame_done),
        .fill_count  (fill_count),
        .fill_a      (fill_a.ram),
        .fill_b      (fill_b.ram),
        .drain_a     (drain_a.ram),
        .drain_b     (drain_b.ram),
        .bank0_a     (bank0_a.user),
        .bank0_b     (bank0_b.user),
        .bank1_a     (bank1_a.user),
        .bank1_b     (bank1_b.user),
        .drain_start (drain_start),
        .drain_count (drain_count),
        .drain_busy  (drain_busy)
    );

    dual_write_ram bank0_i (
        .iClock (iClock),
        .port_a (bank0_a.ram),
        .port_b (bank0_b.ram)
    );

    dual_write_ram bank1_i (
        .iClock (iClock),
        .port_a (bank1_a.ram),
        .port_b (bank1_b.ram)
    );

    drain_reader drain_reader_i (
        .iClock      (iClock),
        .reset       (reset),
        .enable      (enable),
        .clear       (clear),
        .drain_start (drain_start),
        .drain_count (drain_count),
        .drain_a     (drain_a.user),
        .drain_b     (drain_b.user),
        .drain_busy  (drain_busy),
        .data        (data),
        .valid       (valid)
    );

endmodule

//--- hdl/word_fill.sv
// Fills the current bank from address 0; a frame may hold at most one bank of words.
`timescale 1ns/1ps
`include "out_stage_defs.svh"

module word_fill import out_stage_pkg::*; (
    input  logic     iClock,
    input  logic     reset,
    input  logic     enable,
    input  logic     clear,
    input  logic     word_valid,
    input  word_t    word_data,
    input  logic     frame_done,
    output count_t   fill_count,
    ram_port_if.user fill_a,
    ram_port_if.user fill_b
);

    count_t word_count;    // Words accepted in this frame.
    addr_t  next_addr;
    logic   we_a;
    logic   we_b;
    addr_t  wr_addr;
    word_t  wr_data;

    assign next_addr  = addr_t'(word_count);
    assign fill_count = word_count + count_t'(word_valid);    // Counts a word sent with frame_done.

    always_ff @(posedge iClock) begin
        if (reset) begin
            word_count <= '0;
            we_a       <= 1'b0;
            we_b       <= 1'b0;
        end else if (enable) begin
            if (clear) begin
                word_count <= '0;
                we_a       <= 1'b0;
                we_b       <= 1'b0;
            end else begin
                we_a <= word_valid && !next_addr[0];    // Even addresses use port a.
                we_b <= word_valid && next_addr[0];
                if (frame_done) begin
                    word_count <= '0;
                end else if (word_valid) begin
                    word_count <= word_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (enable && word_valid) begin
            wr_addr <= next_addr;
            wr_data <= word_data;
        end
    end

    assign fill_a.we    = we_a && enable;
    assign fill_a.waddr = wr_addr;
    assign fill_a.wdata = wr_data;
    assign fill_a.raddr = '0;
    assign fill_b.we    = we_b && enable;
    assign fill_b.waddr = wr_addr;
    assign fill_b.wdata = wr_data;
    assign fill_b.raddr = '0;

    a_bank_not_full: assert property (
        @(posedge iClock) disable iff (reset)
        word_valid && enable && !clear |-> word_count < `OUT_DEPTH
    ) else $error("Word sent into a full bank.");

endmodule

//--- output_buffer/bank_switch.sv
// Ping-pong routing of two banks. The fill side follows the swap one cycle late to finish its last write.
`timescale 1ns/1ps

module bank_switch import out_stage_pkg::*; (
    input  logic     iClock,
    input  logic     reset,
    input  logic     enable,
    input  logic     clear,
    input  logic     frame_done,
    input  count_t   fill_count,
    ram_port_if.ram  fill_a,
    ram_port_if.ram  fill_b,
    ram_port_if.ram  drain_a,
    ram_port_if.ram  drain_b,
    ram_port_if.user bank0_a,
    ram_port_if.user bank0_b,
    ram_port_if.user bank1_a,
    ram_port_if.user bank1_b,
    output logic     drain_start,
    output count_t   drain_count,
    input  logic     drain_busy
);

    logic sel;         // 0 routes fill to bank 0 and drain to bank 1.
    logic fill_sel;    // Select seen by the fill side.
    logic swap;

    assign swap = frame_done && !clear && fill_count != '0;

    always_ff @(posedge iClock) begin
        if (reset) begin
            sel         <= 1'b0;
            fill_sel    <= 1'b0;
            drain_start <= 1'b0;
        end else if (enable) begin
            fill_sel    <= sel;
            drain_start <= swap;
            if (swap) begin
                sel <= !sel;
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (enable && frame_done) begin
            drain_count <= fill_count;
        end
    end

    // Fill writes win a bank; the drain is idle in the one cycle where both point at it.
    assign bank0_a.we    = !fill_sel ? fill_a.we : (sel && drain_a.we);
    assign bank0_a.waddr = !fill_sel ? fill_a.waddr : drain_a.waddr;
    assign bank0_a.wdata = !fill_sel ? fill_a.wdata : drain_a.wdata;
    assign bank0_a.raddr = sel ? drain_a.raddr : fill_a.raddr;
    assign bank0_b.we    = !fill_sel ? fill_b.we : (sel && drain_b.we);
    assign bank0_b.waddr = !fill_sel ? fill_b.waddr : drain_b.waddr;
    assign bank0_b.wdata = !fill_sel ? fill_b.wdata : drain_b.wdata;
    assign bank0_b.raddr = sel ? drain_b.raddr : fill_b.raddr;

    assign bank1_a.we    = fill_sel ? fill_a.we : (!sel && drain_a.we);
    assign bank1_a.waddr = fill_sel ? fill_a.waddr : drain_a.waddr;
    assign bank1_a.wdata = fill_sel ? fill_a.wdata : drain_a.wdata;
    assign bank1_a.raddr = !sel ? drain_a.raddr : fill_a.raddr;
    assign bank1_b.we    = fill_sel ? fill_b.we : (!sel && drain_b.we);
    assign bank1_b.waddr = fill_sel ? fill_b.waddr : drain_b.waddr;
    assign bank1_b.wdata = fill_sel ? fill_b.wdata : drain_b.wdata;
    assign bank1_b.raddr = !sel ? drain_b.raddr : fill_b.raddr;

    assign drain_a.rdata = sel ? bank0_a.rdata : bank1_a.rdata;
    assign drain_b.rdata = sel ? bank0_b.rdata : bank1_b.rdata;
    assign fill_a.rdata  = fill_sel ? bank1_a.rdata : bank0_a.rdata;
    assign fill_b.rdata  = fill_sel ? bank1_b.rdata : bank0_b.rdata;

    // A swap during a drain would move the reader onto the bank being filled.
    a_no_swap_while_draining: assert property (
        @(posedge iClock) disable iff (reset)
        frame_done && enable && !clear |-> !(drain_busy || drain_start)
    ) else $error("frame_done arrived while a drain was running.");

endmodule

//--- output_buffer/drain_reader.sv
// Drains one bank in address pairs with no back-pressure. Only enable can stall the stream.
`timescale 1ns/1ps

module drain_reader import out_stage_pkg::*; (
    input  logic     iClock,
    input  logic     reset,
    input  logic     enable,
    input  logic     clear,
    input  logic     drain_start,
    input  count_t   drain_count,
    ram_port_if.user drain_a,
    ram_port_if.user drain_b,
    output logic     drain_busy,
    output beat_t    data,
    output logic     valid
);

    logic   busy;          // A read pair is issued each cycle.
    addr_t  rd_addr;       // Even address of the pair being read.
    addr_t  shown_addr;    // Even address of the pair on the RAM outputs.
    count_t beats_left;
    addr_t  ram_addr;

    always_ff @(posedge iClock) begin
        if (reset) begin
            busy       <= 1'b0;
            valid      <= 1'b0;
            rd_addr    <= '0;
            shown_addr <= '0;
            beats_left <= '0;
        end else if (enable) begin
            shown_addr <= rd_addr;
            if (clear) begin
                busy  <= 1'b0;
                valid <= 1'b0;
            end else begin
                valid <= busy;
                if (drain_start) begin
                    busy       <= 1'b1;
                    rd_addr    <= '0;
                    beats_left <= (drain_count + 1'b1) >> 1;    // One beat per word pair.
                end else if (busy) begin
                    rd_addr    <= rd_addr + 2'd2;
                    beats_left <= beats_left - 1'b1;
                    if (beats_left == count_t'(1)) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // While frozen, the shown pair is read again so the RAM outputs hold still.
    assign ram_addr      = enable ? rd_addr : shown_addr;
    assign drain_a.raddr = ram_addr;
    assign drain_b.raddr = ram_addr | addr_t'(1);

    // The pair on the outputs is cleared as it leaves, so the bank is clean for reuse.
    assign drain_a.we    = valid && enable;
    assign drain_a.waddr = shown_addr;
    assign drain_a.wdata = '0;
    assign drain_b.we    = valid && enable;
    assign drain_b.waddr = shown_addr | addr_t'(1);
    assign drain_b.wdata = '0;

    assign data       = pack_beat(drain_a.rdata, drain_b.rdata);
    assign drain_busy = busy || valid;

    // Only the final beat may still show after the last pair is issued.
    a_no_valid_when_idle: assert property (
        @(posedge iClock) disable iff (reset) valid && !busy |-> beats_left == '0
    ) else $error("valid is high while the reader is idle with beats left.");

endmodule

//--- output_buffer/dual_write_ram.sv
// Bank with two write ports; the two ports must never write the same address in one cycle.
`timescale 1ns/1ps
`include "out_stage_defs.svh"

module dual_write_ram import out_stage_pkg::*; (
    input logic     iClock,
    ram_port_if.ram port_a,
    ram_port_if.ram port_b
);

    // Starts at zero so an odd final word of the first frame reads as zero.
    word_t mem [`OUT_DEPTH] = '{default: '0};

    always_ff @(posedge iClock) begin
        if (port_a.we) begin
            mem[port_a.waddr] <= port_a.wdata;
        end
        if (port_b.we) begin
            mem[port_b.waddr] <= port_b.wdata;
        end
        port_a.rdata <= mem[port_a.raddr];    // Old data on a read during write.
        port_b.rdata <= mem[port_b.raddr];
    end

    a_no_write_collision: assert property (
        @(posedge iClock) port_a.we && port_b.we |-> port_a.waddr != port_b.waddr
    ) else $error("Both write ports hit address %0d.", port_a.waddr);

endmodule

//--- test/tb_output_stage.sv
// Frames stay far below one bank, and no frame_done is sent while a drain is still running.
`timescale 1ns/1ps
`include "out_stage_defs.svh"

module tb_output_stage import out_stage_pkg::*; ();

    localparam int DRAIN_TIMEOUT = 4 * `OUT_DEPTH;    // Cycles, frozen ones included.

    logic  iClock = 1'b0;
    logic  reset;
    logic  enable;
    logic  clear;
    logic  word_valid;
    word_t word_data;
    logic  frame_done;
    beat_t data;
    logic  valid;

    int frame_words;    // Size of the frame that frame_done closes.
    int frame_len;
    int frames_sent;
    int beats_seen;
    int errors;

    word_t model_mem [2][`OUT_DEPTH] = '{default: '0};
    logic  model_sel;     // Bank being filled.
    logic  model_valid;
    logic  model_tail;
    beat_t model_beat;
    int    model_fill;
    int    model_lead;    // Edges left before the first beat.
    int    model_beats;
    int    model_total;
    int    model_rd;
    int    model_shown;
    logic  exp_valid;
    logic  exp_odd_tail;
    beat_t exp_beat;
    logic  drain_active;

    output_stage_top output_stage_top_i (
        .iClock     (iClock),
        .reset      (reset),
        .enable     (enable),
        .clear      (clear),
        .word_valid (word_valid),
        .word_data  (word_data),
        .frame_done (frame_done),
        .data       (data),
        .valid      (valid)
    );

    always #5 iClock = ~iClock;

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8]};
    endfunction

    function automatic void report_mismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    // Cycle model of both banks, the swap and the drain.
    always @(posedge iClock) begin
        if (reset) begin
            model_sel   = 1'b0;
            model_valid = 1'b0;
            model_tail  = 1'b0;
            model_beat  = '0;
            model_fill  = 0;
            model_lead  = 0;
            model_beats = 0;
        end else if (enable) begin
            if (model_valid) begin
                model_mem[!model_sel][model_shown]     = '0;    // Pairs are cleared as they leave.
                model_mem[!model_sel][model_shown + 1] = '0;
            end
            if (clear) begin
                model_valid = 1'b0;
                model_fill  = 0;
                model_lead  = 0;
                model_beats = 0;
            end else begin
                if (word_valid) begin
                    model_mem[model_sel][model_fill] = word_data;
                    model_fill++;
                end
                if (model_lead == 1 || model_valid) begin
                    model_valid = model_beats > 0;
                    if (model_valid) begin
                        model_shown = model_rd;
                        model_beat  = {swap_bytes(model_mem[!model_sel][model_rd + 1]),
                                       swap_bytes(model_mem[!model_sel][model_rd])};
                        model_tail  = model_beats == 1 && model_total % 2 == 1;
                        model_rd += 2;
                        model_beats--;
                    end
                end
                if (model_lead > 0) begin
                    model_lead--;
                end
                if (frame_done && model_fill > 0) begin
                    model_sel   = !model_sel;
                    model_lead  = 2;
                    model_beats = (model_fill + 1) / 2;
                    model_total = model_fill;
                    model_rd    = 0;
                end
                if (frame_done) begin
                    model_fill = 0;
                end
            end
        end
        exp_valid    <= model_valid;
        exp_beat     <= model_beat;
        exp_odd_tail <= model_tail;
        drain_active <= model_valid || model_lead > 0;
        if (!reset && enable && valid) begin
            beats_seen++;
        end
    end

    a_beat_matches_model: assert property (
        @(posedge iClock) disable iff (reset) valid |-> data == exp_beat
    ) else report_mismatch($sformatf("beat %h, expected %h",
                                     $sampled(data), $sampled(exp_beat)));

    a_valid_matches_model: assert property (
        @(posedge iClock) disable iff (reset) valid == exp_valid
    ) else report_mismatch($sformatf("valid is %0b, expected %0b",
                                     $sampled(valid), $sampled(exp_valid)));

    a_first_beat_latency: assert property (
        @(posedge iClock) disable iff (reset)
        frame_done && enable && !clear && frame_words != 0 |-> ##2 !valid ##1 valid
    ) else report_mismatch("first beat not two cycles after frame_done");

    a_odd_tail_cleared: assert property (
        @(posedge iClock) disable iff (reset) valid && exp_odd_tail |-> data[31:16] == '0
    ) else report_mismatch("upper half of the last odd beat is not zero");

    a_freeze_holds: assert property (
        @(posedge iClock) disable iff (reset)
        !enable |=> $stable(valid) && (!valid || $stable(data))
    ) else report_mismatch("output moved while enable was low");

    a_clear_drops_valid: assert property (
        @(posedge iClock) disable iff (reset) clear && enable |=> !valid
    ) else report_mismatch("valid stayed high after clear");

    a_empty_frame_silent: assert property (
        @(posedge iClock) disable iff (reset)
        frame_done && enable && !clear && frame_words == 0 |=> !valid [*3]
    ) else report_mismatch("empty frame produced a beat");

    task automatic send_words(input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            repeat ($urandom_range(max_gap, 0)) begin
                @(posedge iClock);
                word_valid <= 1'b0;
            end
            @(posedge iClock);
            word_valid <= 1'b1;
            word_data  <= word_t'($urandom);
            frame_len++;
        end
        @(posedge iClock);
        word_valid <= 1'b0;
    endtask

    task automatic wait_drain_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge iClock);
            cycles++;
        end while (drain_active && cycles < DRAIN_TIMEOUT);
        if (drain_active) begin
            $display("Timeout: the drain did not finish within %0d cycles.", DRAIN_TIMEOUT);
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic end_frame(input logic with_word);
        wait_drain_done();
        frame_done  <= 1'b1;
        word_valid  <= with_word;    // A word sent with frame_done closes the frame.
        word_data   <= word_t'($urandom);
        frame_words <= frame_len + int'(with_word);
        if (frame_len + int'(with_word) > 0) begin
            frames_sent++;
        end
        frame_len = 0;
        @(posedge iClock);
        frame_done <= 1'b0;
        word_valid <= 1'b0;
    endtask

    task automatic hold_enable_low(input int cycles);
        @(posedge iClock);
        enable <= 1'b0;
        repeat (cycles) @(posedge iClock);
        enable <= 1'b1;
    endtask

    task automatic pulse_clear();
        @(posedge iClock);
        clear <= 1'b1;
        @(posedge iClock);
        clear <= 1'b0;
        frame_len = 0;
    endtask

    initial begin
        void'($urandom(32'he1bb6010));
        reset       = 1'b1;
        enable      = 1'b1;
        clear       = 1'b0;
        word_valid  = 1'b0;
        word_data   = '0;
        frame_done  = 1'b0;
        frame_words = 0;
        frame_len   = 0;
        frames_sent = 0;
        beats_seen  = 0;
        errors      = 0;
        repeat (2) @(posedge iClock);
        reset <= 1'b0;
        send_words(40, 0);
        end_frame(1'b0);
        send_words(17, 2);    // Fills bank 1 while bank 0 drains.
        end_frame(1'b1);
        send_words(13, 1);    // Odd frame over the cleared remains of the first one.
        end_frame(1'b0);
        end_frame(1'b0);
        repeat (4) @(posedge iClock);
        for (int f = 0; f < 6; f++) begin
            send_words($urandom_range(30, 1), 3);
            end_frame(1'($urandom_range(1, 0)));
        end
        send_words(24, 0);
        end_frame(1'b0);
        repeat (4) @(posedge iClock);
        hold_enable_low(5);
        repeat (3) @(posedge iClock);
        hold_enable_low(2);
        send_words(30, 0);
        end_frame(1'b0);
        repeat (6) @(posedge iClock);
        pulse_clear();    // Aborts the drain halfway.
        send_words(10, 1);
        end_frame(1'b1);
        wait_drain_done();
        repeat (3) @(posedge iClock);
        $display("Frames %0d, beats %0d, errors %0d.", frames_sent, beats_seen, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/out_stage_pkg.sv
common/ram_port_if.sv
output_buffer/dual_write_ram.sv
output_buffer/bank_switch.sv
output_buffer/drain_reader.sv
hdl/word_fill.sv
hdl/output_stage_top.sv
test/tb_output_stage.sv
